// File: source/vng_pkg.sv
package vng_pkg;

    // datapath widths
    localparam int PX_W  = 8;
    localparam int SUM_W = PX_W + 1;

    // sequence and history
    localparam int         STEPS      = 12;
    localparam logic [3:0] ST_LAST    = 4'(STEPS - 1);
    localparam int         HIST_DEPTH = 16;

    // output flow control
    localparam int CREDITS  = 4;
    localparam int CREDIT_W = $clog2(CREDITS + 1);

    // red is held back by this many red pushes
    localparam int RED_DELAY = 4;

    // red source codes
    localparam logic [1:0] RED_SRC_PX   = 2'd0;
    localparam logic [1:0] RED_SRC_SUM  = 2'd1;
    localparam logic [1:0] RED_SRC_DIAG = 2'd2;

    // per-step tables with step 0 as the rightmost entry
    localparam logic [STEPS-1:0][3:0] TAP_A_TABLE =
        {4'd13, 4'd13, 4'd13, 4'd15, 4'd11, 4'd13, 4'd14, 4'd13, 4'd5, 4'd14, 4'd11, 4'd13};
    localparam logic [STEPS-1:0][3:0] TAP_B_TABLE =
        {4'd11, 4'd3, 4'd3, 4'd13, 4'd1, 4'd11, 4'd12, 4'd11, 4'd15, 4'd4, 4'd13, 4'd3};

    localparam logic [STEPS-1:0] H_TABLE          = 12'b1010_1101_0001;
    localparam logic [STEPS-1:0] RED_PUSH_TABLE   = 12'b1000_0011_1110;
    localparam logic [STEPS-1:0] GREEN_PUSH_TABLE = 12'b1100_1011_0001;
    localparam logic [STEPS-1:0] GREEN_SEL_TABLE  = 12'b1001_0100_0000;
    localparam logic [STEPS-1:0] BLUE_PUSH_TABLE  = 12'b0111_1100_0000;
    localparam logic [STEPS-1:0] BLUE_SEL_TABLE   = 12'b0110_1000_0000;

    localparam logic [STEPS-1:0][1:0] RED_SEL_TABLE =
        {2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd0, 2'd1, 2'd2, 2'd1, 2'd1, 2'd0, 2'd2};

    // everything one step needs from the tables
    typedef struct packed {
        logic [3:0] tap_a;
        logic [3:0] tap_b;
        logic       is_h;
        logic       red_push;
        logic [1:0] red_sel;
        logic       green_push;
        logic       green_sel;
        logic       blue_push;
        logic       blue_sel;
    } step_ctrl_t;

    // one result beat
    typedef struct packed {
        logic             is_h;
        logic [PX_W-1:0]  grad;
        logic             red_valid;
        logic [SUM_W-1:0] red;
        logic             green_valid;
        logic [SUM_W-1:0] green;
        logic             blue_valid;
        logic [SUM_W-1:0] blue;
    } axes_beat_t;

endpackage

// File: source/vng_tap_shiftreg.sv
`timescale 1ns/1ns

module vng_tap_shiftreg (
    input  logic                     clk,
    input  logic                     step_en,
    input  logic [vng_pkg::PX_W-1:0] px,
    input  vng_pkg::step_ctrl_t      ctrl,
    output logic [vng_pkg::PX_W-1:0] tap_a,
    output logic [vng_pkg::PX_W-1:0] tap_b
);
    import vng_pkg::*;

    // the incoming pixel makes the 16th entry
    logic [PX_W-1:0]                  hist [HIST_DEPTH-1];
    logic [HIST_DEPTH-1:0][PX_W-1:0] win;

    // index 0 is the pixel taken this step
    always_comb begin
        win[0] = px;
        for (int i = 1; i < HIST_DEPTH; i++) begin
            win[i] = hist[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (step_en) begin
            hist[0] <= px;
            for (int i = 1; i < HIST_DEPTH - 1; i++) begin
                hist[i] <= hist[i-1];
            end
            tap_a <= win[ctrl.tap_a];
            tap_b <= win[ctrl.tap_b];
        end
    end

endmodule

// File: source/vng_step_rom.sv
`timescale 1ns/1ns

module vng_step_rom (
    input  logic                clk,
    input  logic                reset,
    input  logic                step_en,
    input  logic [3:0]          st,
    output vng_pkg::step_ctrl_t ctrl
);
    import vng_pkg::*;

    logic [3:0] st_next;

    function automatic step_ctrl_t decode(input logic [3:0] s);
        step_ctrl_t c;
        c.tap_a      = TAP_A_TABLE[s];
        c.tap_b      = TAP_B_TABLE[s];
        c.is_h       = H_TABLE[s];
        c.red_push   = RED_PUSH_TABLE[s];
        c.red_sel    = RED_SEL_TABLE[s];
        c.green_push = GREEN_PUSH_TABLE[s];
        c.green_sel  = GREEN_SEL_TABLE[s];
        c.blue_push  = BLUE_PUSH_TABLE[s];
        c.blue_sel   = BLUE_SEL_TABLE[s];
        return c;
    endfunction

    // decode one step ahead so ctrl always matches the current st
    assign st_next = (st == ST_LAST) ? 4'd0 : st + 4'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= decode(4'd0);
        end else if (step_en) begin
            ctrl <= decode(st_next);
        end
    end

endmodule

// File: source/vng_step_sequencer.sv
`timescale 1ns/1ns

module vng_step_sequencer (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  logic       beat_pending,
    input  logic       credit_return,
    output logic       in_ready,
    output logic       step_en,
    output logic [3:0] st,
    output logic       out_valid
);
    import vng_pkg::*;

    logic [CREDIT_W-1:0] credits;
    logic [CREDIT_W-1:0] credit_inc;
    logic [CREDIT_W-1:0] credit_dec;

    // a step only happens while a beat can still be sent
    assign in_ready = (credits != '0);
    assign step_en  = in_valid && in_ready;

    // a beat leaves together with the step that follows it
    assign out_valid = step_en && beat_pending;

    assign credit_inc = CREDIT_W'(credit_return);
    assign credit_dec = CREDIT_W'(out_valid);

    always_ff @(posedge clk) begin
        if (reset) begin
            st <= 4'd0;
        end else if (step_en) begin
            if (st == ST_LAST) begin
                st <= 4'd0;
            end else begin
                st <= st + 4'd1;
            end
        end
    end

    // return and send may land in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= CREDIT_W'(CREDITS);
        end else begin
            credits <= credits + credit_inc - credit_dec;
        end
    end

endmodule

// File: source/vng_diag.sv
`timescale 1ns/1ns

module vng_diag (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      step_en,
    input  logic [vng_pkg::SUM_W-1:0] tap_sum,
    output logic [vng_pkg::SUM_W-1:0] diag_sum
);
    import vng_pkg::*;

    logic [SUM_W-1:0] prev_sum;
    logic [SUM_W:0]   pair_sum;

    // two diagonal pairs, averaged with rounding
    assign pair_sum = {1'b0, prev_sum} + {1'b0, tap_sum} + 1'b1;
    assign diag_sum = pair_sum[SUM_W:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_sum <= '0;
        end else if (step_en) begin
            prev_sum <= tap_sum;
        end
    end

endmodule

// File: source/vng_axes.sv
`timescale 1ns/1ns

module vng_axes (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      step_en,
    input  vng_pkg::step_ctrl_t       ctrl,
    input  logic [vng_pkg::PX_W-1:0]  tap_a,
    input  logic [vng_pkg::PX_W-1:0]  tap_b,
    input  logic [vng_pkg::SUM_W-1:0] diag_sum,
    output logic [vng_pkg::SUM_W-1:0] tap_sum,
    output logic                      beat_pending,
    output vng_pkg::axes_beat_t       beat
);
    import vng_pkg::*;

    // control of the step whose taps are now presented
    step_ctrl_t ctrl_q;

    logic [PX_W-1:0]  grad;
    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] px_dbl;
    logic [SUM_W-1:0] red_pre;
    logic             red_step;
    logic             tap_fill;

    logic [RED_DELAY-1:0][SUM_W-1:0] red_dly;
    logic [RED_DELAY-1:0]            red_fill;

    logic             is_h_q;
    logic [PX_W-1:0]  grad_q;
    logic [SUM_W-1:0] red_q;
    logic [SUM_W-1:0] green_q;
    logic [SUM_W-1:0] blue_q;
    logic             red_v;
    logic             green_v;
    logic             blue_v;

    assign grad   = (tap_a >= tap_b) ? tap_a - tap_b : tap_b - tap_a;
    assign sum    = {1'b0, tap_a} + {1'b0, tap_b};
    assign px_dbl = {tap_a, 1'b0};

    always_comb begin
        case (ctrl_q.red_sel)
            RED_SRC_SUM:  red_pre = sum;
            RED_SRC_DIAG: red_pre = diag_sum;
            default:      red_pre = px_dbl;
        endcase
    end

    // red delay only moves on red pushes
    assign red_step = step_en && ctrl_q.red_push;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q       <= '0;
            tap_fill     <= 1'b0;
            beat_pending <= 1'b0;
            red_fill     <= '0;
            red_v        <= 1'b0;
            green_v      <= 1'b0;
            blue_v       <= 1'b0;
        end else if (step_en) begin
            ctrl_q       <= ctrl;
            tap_fill     <= 1'b1;
            beat_pending <= tap_fill;
            if (ctrl_q.red_push) begin
                red_fill <= {red_fill[RED_DELAY-2:0], 1'b1};
            end
            red_v   <= ctrl_q.red_push && red_fill[RED_DELAY-1];
            green_v <= ctrl_q.green_push;
            blue_v  <= ctrl_q.blue_push;
        end
    end

    always_ff @(posedge clk) begin
        if (red_step) begin
            red_dly <= {red_dly[RED_DELAY-2:0], red_pre};
        end
        if (step_en) begin
            tap_sum <= sum;
            is_h_q  <= ctrl_q.is_h;
            grad_q  <= grad;
            // oldest entry about to be pushed out
            red_q   <= red_dly[RED_DELAY-1];
            green_q <= ctrl_q.green_sel ? sum : px_dbl;
            blue_q  <= ctrl_q.blue_sel ? sum : px_dbl;
        end
    end

    assign beat = '{
        is_h:        is_h_q,
        grad:        grad_q,
        red_valid:   red_v,
        red:         red_q,
        green_valid: green_v,
        green:       green_q,
        blue_valid:  blue_v,
        blue:        blue_q
    };

endmodule

// File: source/vng_axes_top.sv
`timescale 1ns/1ns

module vng_axes_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  logic [vng_pkg::PX_W-1:0] px,
    output logic                     in_ready,
    input  logic                     credit_return,
    output logic                     out_valid,
    output vng_pkg::axes_beat_t      out_beat
);
    import vng_pkg::*;

    logic             step_en;
    logic [3:0]       st;
    logic             beat_pending;
    step_ctrl_t       ctrl;
    logic [PX_W-1:0]  tap_a;
    logic [PX_W-1:0]  tap_b;
    logic [SUM_W-1:0] tap_sum;
    logic [SUM_W-1:0] diag_sum;

    vng_step_sequencer i_sequencer (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .beat_pending  (beat_pending),
        .credit_return (credit_return),
        .in_ready      (in_ready),
        .step_en       (step_en),
        .st            (st),
        .out_valid     (out_valid)
    );

    vng_step_rom i_rom (
        .clk     (clk),
        .reset   (reset),
        .step_en (step_en),
        .st      (st),
        .ctrl    (ctrl)
    );

    vng_tap_shiftreg i_taps (
        .clk     (clk),
        .step_en (step_en),
        .px      (px),
        .ctrl    (ctrl),
        .tap_a   (tap_a),
        .tap_b   (tap_b)
    );

    vng_axes i_axes (
        .clk          (clk),
        .reset        (reset),
        .step_en      (step_en),
        .ctrl         (ctrl),
        .tap_a        (tap_a),
        .tap_b        (tap_b),
        .diag_sum     (diag_sum),
        .tap_sum      (tap_sum),
        .beat_pending (beat_pending),
        .beat         (out_beat)
    );

    vng_diag i_diag (
        .clk      (clk),
        .reset    (reset),
        .step_en  (step_en),
        .tap_sum  (tap_sum),
        .diag_sum (diag_sum)
    );

endmodule

// File: bench/vng_axes_model.svh
// pixels, tap sums and red candidates of every step since reset
logic [PX_W-1:0]  px_log    [$];
logic [SUM_W-1:0] sum_log   [$];
logic [SUM_W-1:0] red_cands [$];
axes_beat_t       exp_q     [$];

// pixels from before the first step are unknown
function automatic logic [PX_W-1:0] past_px(input int n, input int back);
    if (n - back < 0) begin
        return 'x;
    end
    return px_log[n - back];
endfunction

function automatic logic [SUM_W-1:0] past_sum(input int n);
    if (n < 0) begin
        return 'x;
    end
    return sum_log[n];
endfunction

task automatic model_step(input logic [PX_W-1:0] p);
    int               n;
    int               s;
    logic [PX_W-1:0]  a;
    logic [PX_W-1:0]  b;
    logic [SUM_W-1:0] sum;
    logic [SUM_W-1:0] dbl;
    logic [SUM_W-1:0] cand;
    logic [SUM_W:0]   pair;
    axes_beat_t       e;
    n = px_log.size();
    s = n % STEPS;
    px_log.push_back(p);
    a = past_px(n, TAP_A_TABLE[s]);
    b = past_px(n, TAP_B_TABLE[s]);
    sum = {1'b0, a} + {1'b0, b};
    dbl = {a, 1'b0};
    // diagonal pair average of the two previous steps
    pair = {1'b0, past_sum(n - 1)} + {1'b0, past_sum(n - 2)} + 1;
    e = '0;
    e.is_h = H_TABLE[s];
    e.grad = (a > b) ? a - b : b - a;
    case (RED_SEL_TABLE[s])
        RED_SRC_PX:   cand = dbl;
        RED_SRC_SUM:  cand = sum;
        RED_SRC_DIAG: cand = pair[SUM_W:1];
        default:      cand = 'x;
    endcase
    if (RED_PUSH_TABLE[s]) begin
        if (red_cands.size() >= RED_DELAY) begin
            e.red_valid = 1'b1;
            e.red       = red_cands[red_cands.size() - RED_DELAY];
        end
        red_cands.push_back(cand);
    end
    e.green_valid = GREEN_PUSH_TABLE[s];
    e.green       = GREEN_SEL_TABLE[s] ? sum : dbl;
    e.blue_valid  = BLUE_PUSH_TABLE[s];
    e.blue        = BLUE_SEL_TABLE[s] ? sum : dbl;
    sum_log.push_back(sum);
    exp_q.push_back(e);
endtask

// File: bench/vng_axes_tb.sv
`timescale 1ns/1ns

module vng_axes_tb;
    import vng_pkg::*;

    localparam int ROWS        = 12;
    localparam int PASSES      = 4;
    localparam int WATCHDOG_NS = ROWS * STEPS * 40;

    typedef struct packed {
        logic [7:0] px;
        logic [3:0] gap;
        logic [5:0] delay;
    } row_t;

    // pixel, gap before it, credit return delay of a beat
    row_t table_rows [ROWS] = '{
        '{8'h12, 4'd0, 6'd1},  '{8'hf0, 4'd1, 6'd2},  '{8'h07, 4'd0, 6'd25},
        '{8'h80, 4'd2, 6'd1},  '{8'h3c, 4'd0, 6'd3},  '{8'hff, 4'd1, 6'd1},
        '{8'h00, 4'd0, 6'd2},  '{8'h5a, 4'd3, 6'd25}, '{8'ha5, 4'd0, 6'd1},
        '{8'h21, 4'd1, 6'd4},  '{8'hc3, 4'd0, 6'd1},  '{8'h99, 4'd2, 6'd2}
    };

    logic             clk;
    logic             reset;
    logic             in_valid;
    logic [PX_W-1:0]  px;
    logic             in_ready;
    logic             credit_return;
    logic             out_valid;
    axes_beat_t       out_beat;

    integer seed = 48142;
    int     value_errs;
    int     proto_errs;
    int     cycle;
    int     beats;
    int     credits_model;
    int     ret_q [$];
    logic   step;

    `include "vng_axes_model.svh"

    vng_axes_top i_vng_axes_top (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .px            (px),
        .in_ready      (in_ready),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_beat      (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            value_errs++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    // unknown expected values come from pixels before the first step
    task automatic compare_beat(input axes_beat_t e, input axes_beat_t a);
        check_value("is_h", e.is_h, a.is_h);
        if (!$isunknown(e.grad)) check_value("grad", e.grad, a.grad);
        check_value("red_valid", e.red_valid, a.red_valid);
        if (e.red_valid && !$isunknown(e.red)) check_value("red", e.red, a.red);
        check_value("green_valid", e.green_valid, a.green_valid);
        if (e.green_valid && !$isunknown(e.green)) check_value("green", e.green, a.green);
        check_value("blue_valid", e.blue_valid, a.blue_valid);
        if (e.blue_valid && !$isunknown(e.blue)) check_value("blue", e.blue, a.blue);
    endtask

    task automatic drive_pixel(input logic [PX_W-1:0] v, input int gap);
        repeat (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
        @(posedge clk);
        in_valid <= 1'b1;
        px       <= v;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (reset) begin
            credit_return <= 1'b0;
        end else if (ret_q.size() > 0 && ret_q[0] <= cycle) begin
            credit_return <= 1'b1;
            void'(ret_q.pop_front());
        end else begin
            credit_return <= 1'b0;
        end
    end

    // everything is sampled half a cycle after the inputs change
    always @(negedge clk) begin
        if (!reset) begin
            step = in_valid && in_ready;
            check_value("in_ready", credits_model != 0, in_ready);
            if (out_valid && !step) begin
                proto_errs++;
                $display("a beat left in a cycle without a step");
            end
            if (step) begin
                check_value("out_valid", px_log.size() >= 2, out_valid);
                if (out_valid) begin
                    if (exp_q.size() == 0) begin
                        proto_errs++;
                        $display("a beat left with no expected beat queued");
                    end else begin
                        compare_beat(exp_q.pop_front(), out_beat);
                    end
                    ret_q.push_back(cycle + table_rows[beats % ROWS].delay);
                    beats++;
                end
                model_step(px);
            end
            credits_model = credits_model + credit_return - out_valid;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the DUT stalled");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int gap;
        reset         = 1'b1;
        in_valid      = 1'b0;
        px            = '0;
        credit_return = 1'b0;
        cycle         = 0;
        beats         = 0;
        value_errs    = 0;
        proto_errs    = 0;
        credits_model = CREDITS;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        // pass 0 runs without gaps and later passes add table and random gaps
        for (int pass = 0; pass < PASSES; pass++) begin
            for (int r = 0; r < ROWS; r++) begin
                gap = 0;
                if (pass == 1 || pass == 3) gap += table_rows[r].gap;
                if (pass >= 2) gap += $unsigned($random(seed)) % 3;
                drive_pixel(table_rows[r].px + PX_W'(pass * 53), gap);
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (credits_model != CREDITS || ret_q.size() != 0) @(negedge clk);
        // the last two steps are still inside the pipeline
        if (exp_q.size() != 2) begin
            proto_errs++;
            $display("beats lost or duplicated, %0d left expected", exp_q.size());
        end
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+bench
source/vng_pkg.sv
source/vng_tap_shiftreg.sv
source/vng_step_rom.sv
source/vng_step_sequencer.sv
source/vng_diag.sv
source/vng_axes.sv
source/vng_axes_top.sv
bench/vng_axes_tb.sv
